// File: vlog.f
hw/id_pkg.sv
hw/id_insn_reg.sv
hw/id_decoder.sv
hw/id_ex_reg.sv
hw/id_stage_top.sv
tb/id_stage_assertions.sv
tb/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it, then check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_stage -f vlog.f
./obj_dir/Vtb_id_stage | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi

// File: tb/tb_id_stage.sv
// testbench of the decode stage that drives id_stage_top and compares its packets with a reference
`timescale 1ns/1ps

module tb_id_stage;

    localparam int TIMEOUT = 200;

    // hand-picked words with the nop first
    // then opcode 0 with rd set, the slt family, a branch, jal and lui
    localparam id_pkg::word_t DIRECTED [9] = '{
        32'h0000_0000, 32'h0000_0F80, 32'h0020_A1B3,
        32'h0020_B1B3, 32'hFFF3_2293, 32'h0013_3293,
        32'h0020_8463, 32'h0100_00EF, 32'h1234_53B7
    };
    localparam id_pkg::funct3_t LOAD_F3 [5] = '{
        id_pkg::F3_LB, id_pkg::F3_LH, id_pkg::F3_LW, id_pkg::F3_LBU, id_pkg::F3_LHU
    };
    localparam id_pkg::funct3_t STORE_F3 [3] = '{id_pkg::F3_SB, id_pkg::F3_SH, id_pkg::F3_SW};
    localparam id_pkg::funct3_t ARITH_F3 [6] = '{
        id_pkg::F3_ADD, id_pkg::F3_SLL, id_pkg::F3_XOR,
        id_pkg::F3_SR, id_pkg::F3_OR, id_pkg::F3_AND
    };
    localparam logic [6:0] OPC_KEPT [4] = '{
        id_pkg::OPC_LOAD, id_pkg::OPC_OP_IMM, id_pkg::OPC_OP, id_pkg::OPC_STORE
    };

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    id_pkg::fetch_pkt_t in_pkt;
    id_pkg::reg_addr_t  gpr_rd_addr_0;
    id_pkg::reg_addr_t  gpr_rd_addr_1;
    id_pkg::word_t      gpr_rd_data_0;
    id_pkg::word_t      gpr_rd_data_1;
    logic               out_valid;
    logic               out_ready;
    id_pkg::id_ex_pkt_t out_pkt;

    // tb state
    id_pkg::word_t      gpr_mem [32];
    logic [31:0]        lfsr_state;
    id_pkg::id_ex_pkt_t exp_q [$];
    int                 acc_q [$];
    id_pkg::id_ex_pkt_t exp_pkt;
    int                 acc_edge;
    id_pkg::word_t      held_insn;
    logic               held_valid = 1'b0;
    int                 cyc = 0;
    int                 n_checked = 0;
    int                 check_errs = 0;
    int                 other_errs = 0;
    logic               stream_mode = 1'b0;
    logic               backpressure = 1'b0;

    id_stage_top uut (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .in_valid_i      (in_valid),
        .in_ready_o      (in_ready),
        .in_pkt_i        (in_pkt),
        .gpr_rd_addr_0_o (gpr_rd_addr_0),
        .gpr_rd_addr_1_o (gpr_rd_addr_1),
        .gpr_rd_data_0_i (gpr_rd_data_0),
        .gpr_rd_data_1_i (gpr_rd_data_1),
        .out_valid_o     (out_valid),
        .out_ready_i     (out_ready),
        .out_pkt_o       (out_pkt)
    );

    // register file answers in the same cycle
    assign gpr_rd_data_0 = gpr_mem[gpr_rd_addr_0];
    assign gpr_rd_data_1 = gpr_mem[gpr_rd_addr_1];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // edge counter for latency
    always @(posedge clk) cyc <= cyc + 1;

    // --------------------------------------------------
    // random source from a 32 bit galois lfsr
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    function automatic id_pkg::word_t make_insn();
        logic [2:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] opc;
        int         p;
        kind = 3'(take_bits(3));
        rd   = 5'(take_bits(5));
        rs1  = 5'(take_bits(5));
        rs2  = 5'(take_bits(5));
        f3   = 3'(take_bits(3));
        f7   = 7'(take_bits(7));
        p    = int'(take_bits(5));
        // immediates live in the random f7 / rs2 / rd fields
        case (kind)
            3'd0: begin
                opc = id_pkg::OPC_LOAD;
                f3  = LOAD_F3[p % 5];
            end
            3'd1: begin
                opc = id_pkg::OPC_STORE;
                f3  = STORE_F3[p % 3];
            end
            3'd2, 3'd4: begin
                opc = id_pkg::OPC_OP_IMM;
                f3  = ARITH_F3[p % 6];
                if (f3 == id_pkg::F3_SLL) f7 = id_pkg::F7_BASE;
                if (f3 == id_pkg::F3_SR) f7 = p[4] ? id_pkg::F7_ALT : id_pkg::F7_BASE;
            end
            3'd3: begin
                opc = id_pkg::OPC_OP;
                f3  = ARITH_F3[p % 6];
                f7  = id_pkg::F7_BASE;
                if (p[4] && (f3 == id_pkg::F3_ADD || f3 == id_pkg::F3_SR)) f7 = id_pkg::F7_ALT;
            end
            // kept opcode with funct fields left random
            3'd5: opc = OPC_KEPT[p % 4];
            3'd6: opc = {5'(take_bits(5)), 2'b11};
            default: return '0;
        endcase
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // --------------------------------------------------
    // reference decode straight from the isa encodings
    // --------------------------------------------------
    function automatic id_pkg::id_ex_pkt_t ref_decode(input id_pkg::word_t w,
                                                      input id_pkg::word_t a,
                                                      input id_pkg::word_t b);
        id_pkg::id_ex_pkt_t p;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic               legal;
        logic               we;
        id_pkg::alu_op_e    op;
        id_pkg::mem_op_e    mop;
        id_pkg::word_t      opnd;
        f3    = w[14:12];
        f7    = w[31:25];
        legal = 1'b1;
        we    = 1'b1;
        op    = id_pkg::ALU_ADD;
        mop   = id_pkg::MEM_NOP;
        opnd  = b;
        p.alu_op      = id_pkg::ALU_NOP;
        p.alu_in_0    = a;
        p.alu_in_1    = b;
        p.mem_op      = id_pkg::MEM_NOP;
        p.mem_wr_data = b;
        p.dst_addr    = w[11:7];
        p.gpr_we      = 1'b0;
        p.illegal     = 1'b0;
        case (w[6:0])
            7'b0000000: begin
                legal = (w == 0);
                op    = id_pkg::ALU_NOP;
                we    = 1'b0;
            end
            7'b0000011: begin
                opnd = {{20{w[31]}}, w[31:20]};
                case (f3)
                    3'b000:  mop = id_pkg::MEM_LB;
                    3'b001:  mop = id_pkg::MEM_LH;
                    3'b010:  mop = id_pkg::MEM_LW;
                    3'b100:  mop = id_pkg::MEM_LBU;
                    3'b101:  mop = id_pkg::MEM_LHU;
                    default: legal = 1'b0;
                endcase
            end
            7'b0100011: begin
                opnd = {{20{w[31]}}, w[31:25], w[11:7]};
                we   = 1'b0;
                case (f3)
                    3'b000:  mop = id_pkg::MEM_SB;
                    3'b001:  mop = id_pkg::MEM_SH;
                    3'b010:  mop = id_pkg::MEM_SW;
                    default: legal = 1'b0;
                endcase
            end
            7'b0010011: begin
                opnd = {{20{w[31]}}, w[31:20]};
                case (f3)
                    3'b000: op = id_pkg::ALU_ADD;
                    3'b100: op = id_pkg::ALU_XOR;
                    3'b110: op = id_pkg::ALU_OR;
                    3'b111: op = id_pkg::ALU_AND;
                    3'b001: begin
                        op    = id_pkg::ALU_SLL;
                        legal = (f7 == 7'b0);
                        opnd  = {27'b0, w[24:20]};
                    end
                    3'b101: begin
                        op    = f7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                        legal = ({f7[6], f7[4:0]} == 6'b0);
                        opnd  = {27'b0, w[24:20]};
                    end
                    // slti / sltiu dropped
                    default: legal = 1'b0;
                endcase
            end
            7'b0110011: begin
                case ({f7, f3})
                    {7'h00, 3'b000}: op = id_pkg::ALU_ADD;
                    {7'h20, 3'b000}: op = id_pkg::ALU_SUB;
                    {7'h00, 3'b001}: op = id_pkg::ALU_SLL;
                    {7'h00, 3'b101}: op = id_pkg::ALU_SRL;
                    {7'h20, 3'b101}: op = id_pkg::ALU_SRA;
                    {7'h00, 3'b100}: op = id_pkg::ALU_XOR;
                    {7'h00, 3'b110}: op = id_pkg::ALU_OR;
                    {7'h00, 3'b111}: op = id_pkg::ALU_AND;
                    default:         legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        // illegal words keep every default
        if (!legal) begin
            p.illegal = 1'b1;
        end else begin
            p.alu_op   = op;
            p.alu_in_1 = opnd;
            p.mem_op   = mop;
            p.gpr_we   = we;
        end
        return p;
    endfunction

    // --------------------------------------------------
    // one compare task per result type
    // --------------------------------------------------
    task automatic alu_op_check(input string what, input id_pkg::alu_op_e got,
                                input id_pkg::alu_op_e want);
        if (got !== want) begin
            check_errs++;
            $display("CHECK FAILED @%0t: %s got %s exp %s", $time, what, got.name(), want.name());
        end
    endtask

    task automatic mem_op_check(input string what, input id_pkg::mem_op_e got,
                                input id_pkg::mem_op_e want);
        if (got !== want) begin
            check_errs++;
            $display("CHECK FAILED @%0t: %s got %s exp %s", $time, what, got.name(), want.name());
        end
    endtask

    task automatic word_check(input string what, input id_pkg::word_t got,
                              input id_pkg::word_t want);
        if (got !== want) begin
            check_errs++;
            $display("CHECK FAILED @%0t: %s got %h exp %h", $time, what, got, want);
        end
    endtask

    task automatic addr_check(input string what, input id_pkg::reg_addr_t got,
                              input id_pkg::reg_addr_t want);
        if (got !== want) begin
            check_errs++;
            $display("CHECK FAILED @%0t: %s got %0d exp %0d", $time, what, got, want);
        end
    endtask

    task automatic flag_check(input string what, input logic got, input logic want);
        if (got !== want) begin
            check_errs++;
            $display("CHECK FAILED @%0t: %s got %b exp %b", $time, what, got, want);
        end
    endtask

    // --------------------------------------------------
    // output side sampled mid-cycle where all is stable
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && stream_mode && !in_ready) begin
            other_errs++;
            $display("in_ready_o dropped during a continuous stream at %0t", $time);
        end
        // read port follows rs1 / rs2 of the last accepted word
        if (rst_n && held_valid) begin
            addr_check("gpr_rd_addr_0_o", gpr_rd_addr_0, held_insn[19:15]);
            addr_check("gpr_rd_addr_1_o", gpr_rd_addr_1, held_insn[24:20]);
        end
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("a packet came out at %0t although none was expected", $time);
            end else begin
                exp_pkt  = exp_q.pop_front();
                acc_edge = acc_q.pop_front();
                alu_op_check("alu_op", out_pkt.alu_op, exp_pkt.alu_op);
                word_check("alu_in_0", out_pkt.alu_in_0, exp_pkt.alu_in_0);
                word_check("alu_in_1", out_pkt.alu_in_1, exp_pkt.alu_in_1);
                mem_op_check("mem_op", out_pkt.mem_op, exp_pkt.mem_op);
                word_check("mem_wr_data", out_pkt.mem_wr_data, exp_pkt.mem_wr_data);
                addr_check("dst_addr", out_pkt.dst_addr, exp_pkt.dst_addr);
                flag_check("gpr_we", out_pkt.gpr_we, exp_pkt.gpr_we);
                flag_check("illegal", out_pkt.illegal, exp_pkt.illegal);
                // two edges from accept to output transfer when never stalled
                if (acc_edge >= 0 && cyc + 1 - acc_edge != 2) begin
                    check_errs++;
                    $display("CHECK FAILED @%0t: latency got %0d edges exp 2", $time,
                             cyc + 1 - acc_edge);
                end
                n_checked++;
            end
        end
    end

    // --------------------------------------------------
    // input side
    // --------------------------------------------------
    task automatic fail_on_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("Regression failed");
        $finish;
    endtask

    // next drive point just after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
        out_ready = backpressure ? (take_bits(2) != 0) : 1'b1;
    endtask

    task automatic send_insn(input id_pkg::word_t w);
        int waited;
        waited      = 0;
        in_valid    = 1'b1;
        in_pkt.insn = w;
        @(negedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            step_cycle();
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            fail_on_timeout("in_ready_o");
        end else begin
            // operands as the register file holds them now
            exp_q.push_back(ref_decode(w, gpr_mem[w[19:15]], gpr_mem[w[24:20]]));
            acc_q.push_back(stream_mode ? cyc + 1 : -1);
            step_cycle();
            held_insn  = w;
            held_valid = 1'b1;
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected packets never reached the output", exp_q.size());
            fail_on_timeout("the pipeline to drain");
        end else begin
            // a few idle cycles to expose duplicates
            repeat (4) step_cycle();
        end
    endtask

    initial begin
        lfsr_state  = 32'd72;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_pkt      = '0;
        out_ready   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            gpr_mem[i] = (i == 0) ? '0 : take_bits(32);
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n     = 1'b1;
        out_ready = 1'b1;

        // idle after reset
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            flag_check("out_valid_o after reset", out_valid, 1'b0);
            flag_check("in_ready_o after reset", in_ready, 1'b1);
            step_cycle();
        end

        // back to back stream with ex always ready
        stream_mode = 1'b1;
        foreach (DIRECTED[i]) send_insn(DIRECTED[i]);
        for (int i = 0; i < 60; i++) send_insn(make_insn());
        drain_pipeline();
        stream_mode = 1'b0;

        // random gaps and random ex stalls
        backpressure = 1'b1;
        for (int i = 0; i < 300; i++) begin
            if (take_bits(2) == 0) begin
                in_valid = 1'b0;
                step_cycle();
            end
            send_insn(make_insn());
        end
        drain_pipeline();

        $display("packets checked %0d, check errors %0d, other errors %0d",
                 n_checked, check_errs, other_errs);
        if (check_errs == 0 && other_errs == 0 && n_checked == 369) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/id_stage_assertions.sv
// concurrent handshake and packet checks, bound into every id_stage_top instance
`timescale 1ns/1ps

module id_stage_assertions (
    input logic               clk,
    input logic               rst_n_i,
    input logic               out_valid_o,
    input logic               out_ready_i,
    input id_pkg::id_ex_pkt_t out_pkt_o
);

    // --------------------------------------------------
    // reset
    // --------------------------------------------------
    // a reset edge always empties the output register
    valid_low_after_reset: assert property (
        @(posedge clk) !rst_n_i |=> !out_valid_o
    ) else $error("out_valid_o high in the cycle after reset");

    // --------------------------------------------------
    // output handshake
    // --------------------------------------------------
    // stalled packet stays put until ex takes it
    pkt_stable_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pkt_o)
    ) else $error("output packet changed while stalled");

    // illegal words must not write or touch memory
    illegal_no_side_effects: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_valid_o && out_pkt_o.illegal |->
            !out_pkt_o.gpr_we && out_pkt_o.mem_op == id_pkg::MEM_NOP
    ) else $error("illegal packet with a write or memory operation");

endmodule

bind id_stage_top id_stage_assertions u_assertions (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_pkt_o   (out_pkt_o)
);

// File: hw/id_stage_top.sv
// top of the decode stage, chains instruction register, decoder and id/ex register
`timescale 1ns/1ps

module id_stage_top (
    input  logic               clk,
    input  logic               rst_n_i,
    // fetch side
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  id_pkg::fetch_pkt_t in_pkt_i,
    // register-file read port
    output id_pkg::reg_addr_t  gpr_rd_addr_0_o,
    output id_pkg::reg_addr_t  gpr_rd_addr_1_o,
    input  id_pkg::word_t      gpr_rd_data_0_i,
    input  id_pkg::word_t      gpr_rd_data_1_i,
    // ex side
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output id_pkg::id_ex_pkt_t out_pkt_o
);

    // --------------------------------------------------
    // internal links
    // --------------------------------------------------
    logic               insn_valid;
    logic               insn_ready;
    id_pkg::fetch_pkt_t insn_pkt;
    id_pkg::id_ex_pkt_t dec_pkt;

    // if/id register, also addresses the register file
    id_insn_reg u_insn_reg (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .in_valid_i      (in_valid_i),
        .in_ready_o      (in_ready_o),
        .in_pkt_i        (in_pkt_i),
        .insn_valid_o    (insn_valid),
        .insn_ready_i    (insn_ready),
        .insn_pkt_o      (insn_pkt),
        .gpr_rd_addr_0_o (gpr_rd_addr_0_o),
        .gpr_rd_addr_1_o (gpr_rd_addr_1_o)
    );

    // same-cycle decode of the held word
    id_decoder u_decoder (
        .insn_pkt_i      (insn_pkt),
        .gpr_rd_data_0_i (gpr_rd_data_0_i),
        .gpr_rd_data_1_i (gpr_rd_data_1_i),
        .dec_pkt_o       (dec_pkt)
    );

    id_ex_reg u_id_ex_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_valid_i (insn_valid),
        .dec_ready_o (insn_ready),
        .dec_pkt_i   (dec_pkt),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_pkt_o   (out_pkt_o)
    );

endmodule

// File: hw/id_ex_reg.sv
// id/ex pipeline register, presents the decoded packet to ex under valid/ready
`timescale 1ns/1ps

module id_ex_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               dec_valid_i,
    output logic               dec_ready_o,
    input  id_pkg::id_ex_pkt_t dec_pkt_i,
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output id_pkg::id_ex_pkt_t out_pkt_o
);

    logic               out_valid_q;
    id_pkg::id_ex_pkt_t out_pkt_q;

    // empty, or ex takes the current packet this edge
    assign dec_ready_o = !out_valid_q || out_ready_i;

    // valid bit, frozen while ex stalls
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (dec_ready_o) begin
            out_valid_q <= dec_valid_i;
        end
    end

    // packet capture on transfer
    // otherwise held stable for ex
    always_ff @(posedge clk) begin
        if (dec_valid_i && dec_ready_o) begin
            out_pkt_q <= dec_pkt_i;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_pkt_o   = out_pkt_q;

endmodule

// File: hw/id_decoder.sv
// combinational rv32i decoder, turns the held instruction and operands into an id/ex packet
`timescale 1ns/1ps

module id_decoder (
    input  id_pkg::fetch_pkt_t insn_pkt_i,
    input  id_pkg::word_t      gpr_rd_data_0_i,
    input  id_pkg::word_t      gpr_rd_data_1_i,
    output id_pkg::id_ex_pkt_t dec_pkt_o
);

    // --------------------------------------------------
    // instruction fields
    // --------------------------------------------------
    id_pkg::word_t   insn;
    id_pkg::opcode_e opcode;
    id_pkg::funct3_t funct3;
    id_pkg::funct7_t funct7;
    logic            is_shift;

    assign insn     = insn_pkt_i.insn;
    assign opcode   = id_pkg::opcode_e'(insn[6:0]);
    assign funct3   = insn[14:12];
    assign funct7   = insn[31:25];
    // slli, srli, srai take shamt instead of imm_i
    assign is_shift = (funct3 == id_pkg::F3_SLL) || (funct3 == id_pkg::F3_SR);

    // --------------------------------------------------
    // immediates
    // --------------------------------------------------
    id_pkg::word_t imm_i;
    id_pkg::word_t imm_sh;
    id_pkg::word_t imm_s;

    // i type, sign extended
    assign imm_i  = {{20{insn[31]}}, insn[31:20]};
    // 5 bit shift amount, zero extended
    assign imm_sh = {27'b0, insn[24:20]};
    // s type, split across two fields
    assign imm_s  = {{20{insn[31]}}, insn[31:25], insn[11:7]};

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb begin
        // defaults, also the result of nop and illegal words
        dec_pkt_o.alu_op      = id_pkg::ALU_NOP;
        dec_pkt_o.alu_in_0    = gpr_rd_data_0_i;
        dec_pkt_o.alu_in_1    = gpr_rd_data_1_i;
        dec_pkt_o.mem_op      = id_pkg::MEM_NOP;
        dec_pkt_o.mem_wr_data = gpr_rd_data_1_i;
        dec_pkt_o.dst_addr    = insn[11:7];
        dec_pkt_o.gpr_we      = 1'b0;
        dec_pkt_o.illegal     = 1'b0;

        case (opcode)
            id_pkg::OPC_NOP: begin
                // only the all-zero word is a nop
                dec_pkt_o.illegal = (insn != '0);
            end
            id_pkg::OPC_LOAD: begin
                case (funct3)
                    id_pkg::F3_LB:  dec_pkt_o.mem_op = id_pkg::MEM_LB;
                    id_pkg::F3_LH:  dec_pkt_o.mem_op = id_pkg::MEM_LH;
                    id_pkg::F3_LW:  dec_pkt_o.mem_op = id_pkg::MEM_LW;
                    id_pkg::F3_LBU: dec_pkt_o.mem_op = id_pkg::MEM_LBU;
                    id_pkg::F3_LHU: dec_pkt_o.mem_op = id_pkg::MEM_LHU;
                    default:        dec_pkt_o.illegal = 1'b1;
                endcase
                // address is rs1 + imm_i
                if (!dec_pkt_o.illegal) begin
                    dec_pkt_o.alu_op   = id_pkg::ALU_ADD;
                    dec_pkt_o.alu_in_1 = imm_i;
                    dec_pkt_o.gpr_we   = 1'b1;
                end
            end
            id_pkg::OPC_STORE: begin
                case (funct3)
                    id_pkg::F3_SB: dec_pkt_o.mem_op = id_pkg::MEM_SB;
                    id_pkg::F3_SH: dec_pkt_o.mem_op = id_pkg::MEM_SH;
                    id_pkg::F3_SW: dec_pkt_o.mem_op = id_pkg::MEM_SW;
                    default:       dec_pkt_o.illegal = 1'b1;
                endcase
                // address is rs1 + imm_s, no register write
                if (!dec_pkt_o.illegal) begin
                    dec_pkt_o.alu_op   = id_pkg::ALU_ADD;
                    dec_pkt_o.alu_in_1 = imm_s;
                end
            end
            id_pkg::OPC_OP_IMM: begin
                case (funct3)
                    id_pkg::F3_ADD: dec_pkt_o.alu_op = id_pkg::ALU_ADD;
                    id_pkg::F3_XOR: dec_pkt_o.alu_op = id_pkg::ALU_XOR;
                    id_pkg::F3_OR:  dec_pkt_o.alu_op = id_pkg::ALU_OR;
                    id_pkg::F3_AND: dec_pkt_o.alu_op = id_pkg::ALU_AND;
                    id_pkg::F3_SLL: begin
                        if (funct7 == id_pkg::F7_BASE) dec_pkt_o.alu_op = id_pkg::ALU_SLL;
                        else dec_pkt_o.illegal = 1'b1;
                    end
                    id_pkg::F3_SR: begin
                        if (funct7 == id_pkg::F7_BASE) dec_pkt_o.alu_op = id_pkg::ALU_SRL;
                        else if (funct7 == id_pkg::F7_ALT) dec_pkt_o.alu_op = id_pkg::ALU_SRA;
                        else dec_pkt_o.illegal = 1'b1;
                    end
                    // slti / sltiu land here, no comparator
                    default: dec_pkt_o.illegal = 1'b1;
                endcase
                if (!dec_pkt_o.illegal) begin
                    dec_pkt_o.alu_in_1 = is_shift ? imm_sh : imm_i;
                    dec_pkt_o.gpr_we   = 1'b1;
                end
            end
            id_pkg::OPC_OP: begin
                // alternate funct7 only for sub and sra
                if (funct7 == id_pkg::F7_BASE) begin
                    case (funct3)
                        id_pkg::F3_ADD: dec_pkt_o.alu_op = id_pkg::ALU_ADD;
                        id_pkg::F3_SLL: dec_pkt_o.alu_op = id_pkg::ALU_SLL;
                        id_pkg::F3_XOR: dec_pkt_o.alu_op = id_pkg::ALU_XOR;
                        id_pkg::F3_SR:  dec_pkt_o.alu_op = id_pkg::ALU_SRL;
                        id_pkg::F3_OR:  dec_pkt_o.alu_op = id_pkg::ALU_OR;
                        id_pkg::F3_AND: dec_pkt_o.alu_op = id_pkg::ALU_AND;
                        default:        dec_pkt_o.illegal = 1'b1;
                    endcase
                end else if (funct7 == id_pkg::F7_ALT && funct3 == id_pkg::F3_ADD) begin
                    dec_pkt_o.alu_op = id_pkg::ALU_SUB;
                end else if (funct7 == id_pkg::F7_ALT && funct3 == id_pkg::F3_SR) begin
                    dec_pkt_o.alu_op = id_pkg::ALU_SRA;
                end else begin
                    dec_pkt_o.illegal = 1'b1;
                end
                dec_pkt_o.gpr_we = !dec_pkt_o.illegal;
            end
            // branches, jumps, lui, auipc and the rest
            default: dec_pkt_o.illegal = 1'b1;
        endcase
    end

endmodule

// File: hw/id_insn_reg.sv
// if/id instruction register of the decode stage, takes fetched words under valid/ready
`timescale 1ns/1ps

module id_insn_reg (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  id_pkg::fetch_pkt_t in_pkt_i,
    output logic               insn_valid_o,
    input  logic               insn_ready_i,
    output id_pkg::fetch_pkt_t insn_pkt_o,
    output id_pkg::reg_addr_t  gpr_rd_addr_0_o,
    output id_pkg::reg_addr_t  gpr_rd_addr_1_o
);

    logic               insn_valid_q;
    id_pkg::fetch_pkt_t insn_pkt_q;

    // free slot, or the held word leaves on this edge
    assign in_ready_o = !insn_valid_q || insn_ready_i;

    // valid bit
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            insn_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            insn_valid_q <= in_valid_i;
        end
    end

    // instruction word, loaded on accept only
    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            insn_pkt_q <= in_pkt_i;
        end
    end

    assign insn_valid_o = insn_valid_q;
    assign insn_pkt_o   = insn_pkt_q;

    // rs1 / rs2 straight from the held word
    // so operand data is back within the decode cycle
    assign gpr_rd_addr_0_o = insn_pkt_q.insn[19:15];
    assign gpr_rd_addr_1_o = insn_pkt_q.insn[24:20];

endmodule

// File: hw/id_pkg.sv
// shared widths, encodings and packet structs of the decode stage, referenced as id_pkg::name
package id_pkg;

    // --------------------------------------------------
    // widths fixed by the rv32i isa
    // --------------------------------------------------
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int ALU_OP_W   = 4;
    localparam int MEM_OP_W   = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;
    typedef logic [FUNCT7_W-1:0]   funct7_t;

    // --------------------------------------------------
    // major opcodes still decoded
    // --------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OPC_NOP    = 7'b0000000,
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // funct3 of loads
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    // funct3 of stores
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;
    // funct3 of arithmetic, shared by op and op-imm
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_SR  = 3'b101;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // funct7: base form, and alternate for sub / sra / srai
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // --------------------------------------------------
    // operations handed to ex
    // --------------------------------------------------
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [MEM_OP_W-1:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU,
        MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // fetched instruction as it enters decode
    typedef struct packed {
        word_t insn;
    } fetch_pkt_t;

    // decoded packet held in the id/ex register
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     alu_in_0;
        word_t     alu_in_1;
        mem_op_e   mem_op;
        word_t     mem_wr_data;
        reg_addr_t dst_addr;
        // active high register-file write
        logic      gpr_we;
        // undefined encoding, all side effects off
        logic      illegal;
    } id_ex_pkt_t;

endpackage
